// ==== sim.f ====
hdl/pi1_pkg.sv
hdl/soc_map_pkg.sv
hdl/pi1_if.sv
hdl/perint_router.sv
hdl/devtbl.sv
hdl/scratch_ram.sv
hdl/rst_ctrl.sv
hdl/perint_soc.sv
tests/perint_checker.sv
tests/tb_perint_soc.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_perint_soc
RTL_TOP    ?= perint_soc
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= All tests passed!
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '$(PASS_TEXT)' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_perint_soc.sv ====
`default_nettype none

module tb_perint_soc import pi1_pkg::*, soc_map_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [ADDR_BITS-1:0] RAM_BASE = 30'd1024;
	// Byte address 0x2000
	localparam logic [ADDR_BITS-1:0] DEFAULT_BASE = 30'h800;
	localparam int unsigned TEST_WORDS = 64;

	logic                 clk24mhz;
	logic                 rst_p;
	pi1_op_e              op;
	logic [ADDR_BITS-1:0] addr;
	pi1_word_t            wdata;
	logic [SEL_BITS-1:0]  sel;
	pi1_word_t            rdata;
	logic                 rdy;
	logic                 sys_rst;
	int unsigned          err_count;
	int unsigned          check_count;
	logic                 timed_out;
	logic [31:0]          seed;

	perint_soc perint_soc_i (
		.clk24mhz  (clk24mhz),
		.rst_p     (rst_p),
		.op_i      (op),
		.addr_i    (addr),
		.data_i    (wdata),
		.sel_i     (sel),
		.data_o    (rdata),
		.rdy_o     (rdy),
		.sys_rst_o (sys_rst)
	);

	perint_checker perint_checker_i (
		.clk24mhz      (clk24mhz),
		.rst_p         (rst_p),
		.op_i          (op),
		.addr_i        (addr),
		.data_i        (wdata),
		.sel_i         (sel),
		.dut_data_i    (rdata),
		.dut_rdy_i     (rdy),
		.dut_sys_rst_i (sys_rst),
		.err_count_o   (err_count),
		.check_count_o (check_count),
		.timed_out_o   (timed_out)
	);

	initial clk24mhz = 1'b0;
	always #10 clk24mhz = ~clk24mhz;

	function logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic pi1_word_t fill_word(input logic [ADDR_BITS-1:0] a);
		return ({2'b00, a} * 32'h9e3779b1) ^ 32'hc3a55a3c;
	endfunction

	task automatic drive(input pi1_op_e o, input logic [ADDR_BITS-1:0] a, input pi1_word_t d,
		input logic [SEL_BITS-1:0] s);
		@(posedge clk24mhz);
		op <= o;
		addr <= a;
		wdata <= d;
		sel <= s;
	endtask

	task automatic idle(input int unsigned n);
		repeat (n) begin
			@(posedge clk24mhz);
			op <= PI1_NOP;
		end
	endtask

	task automatic wait_ready();
		@(posedge clk24mhz);
		while (rdy !== 1'b1)
			@(posedge clk24mhz);
	endtask

	task automatic ram_readback();
		for (int i = 0; i < TEST_WORDS; i++)
			drive(PI1_RD, RAM_BASE + 30'(i), '0, '0);
		idle(3);
	endtask

	task automatic finish_run();
		$display("closing: %0d checks, %0d errors, timeout %0d", check_count, err_count,
			timed_out);
		if (err_count == 0 && !timed_out)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	initial begin
		@(posedge timed_out);
		finish_run();
	end

	initial begin
		logic [31:0]          r;
		logic [ADDR_BITS-1:0] ra;
		seed = 32'h96a50ee7;
		rst_p = 1'b1;
		op = PI1_NOP;
		addr = '0;
		wdata = '0;
		sel = '0;
		repeat (8) @(posedge clk24mhz);
		rst_p <= 1'b0;
		// Release timing is followed cycle by cycle in the checker
		wait_ready();

		// Device table words 0 to 7
		for (int i = 0; i < 8; i++)
			drive(PI1_RD, 30'(i), '0, '0);
		for (int i = 0; i < TEST_WORDS; i++)
			drive(PI1_WR, RAM_BASE + 30'(i), fill_word(RAM_BASE + 30'(i)), 4'hf);

		// Random byte writes each followed right away by a read
		for (int n = 0; n < 200; n++) begin
			r = next_rand();
			ra = RAM_BASE + 30'(next_rand() % TEST_WORDS);
			drive(PI1_WR, ra, next_rand(), r[31:28]);
			drive(PI1_RD, RAM_BASE + 30'(next_rand() % TEST_WORDS), '0, '0);
		end
		idle(2);

		// Swap followed by a read of the merged word
		drive(PI1_RDWR, RAM_BASE + 30'd5, 32'h1234_5678, 4'b0101);
		drive(PI1_RD, RAM_BASE + 30'd5, '0, '0);
		idle(2);

		// Default device
		drive(PI1_RD, DEFAULT_BASE, '0, '0);
		drive(PI1_WR, DEFAULT_BASE + 30'd5, 32'hdead_beef, 4'hf);
		drive(PI1_RD, 30'h3fff_ffff, '0, '0);
		idle(2);
		ram_readback();

		// Warm reset keeps the RAM
		drive(PI1_WR, '0, 32'h2, 4'h1);
		idle(3);
		wait_ready();
		ram_readback();

		// Power-off holds until the external reset
		drive(PI1_WR, '0, 32'h1, 4'h1);
		idle(40);
		rst_p <= 1'b1;
		repeat (2) @(posedge clk24mhz);
		rst_p <= 1'b0;
		wait_ready();
		ram_readback();
		finish_run();
	end

endmodule

`default_nettype wire

// ==== tests/perint_checker.sv ====
`default_nettype none

module perint_checker import pi1_pkg::*, soc_map_pkg::*; (
	input  logic                 clk24mhz,
	input  logic                 rst_p,
	input  pi1_op_e              op_i,
	input  logic [ADDR_BITS-1:0] addr_i,
	input  pi1_word_t            data_i,
	input  logic [SEL_BITS-1:0]  sel_i,
	input  pi1_word_t            dut_data_i,
	input  logic                 dut_rdy_i,
	input  logic                 dut_sys_rst_i,
	output int unsigned          err_count_o,
	output int unsigned          check_count_o,
	output logic                 timed_out_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// Limit is four times a generous estimate of the run length
	localparam int unsigned RUN_CYCLES_EST = 1000;
	localparam int unsigned TIMEOUT_CYCLES = 4 * RUN_CYCLES_EST;

	pi1_word_t   ref_mem [1024];
	pi1_word_t   exp_data;
	logic        exp_pending;
	int unsigned exp_cnt;
	logic        exp_pwroff;
	logic        exp_sys_rst;
	logic        prev_rst_p;
	logic        model_valid;
	rst_req_e    req_now;
	rst_req_e    req_d1;
	rst_req_e    req_d2;
	int unsigned cycle_cnt;

	// Table words first, then RAM at word 1024 and zero from word 2048 on
	function automatic pi1_word_t ref_read(input logic [ADDR_BITS-1:0] a);
		pi1_word_t word;
		word = '0;
		if (a < 30'd8) begin
			case (a[2:0])
				3'd0: word = 32'd5;
				3'd1: word = 32'd3;
				3'd2: word = 32'd7;
				3'd4: word = 32'd1;
				3'd6: word = 32'd0;
				default: word = 32'd4096;
			endcase
		end else if (a >= 30'd1024 && a < 30'd2048) begin
			word = ref_mem[10'(a - 30'd1024)];
		end
		return word;
	endfunction

	function automatic void ref_write(input logic [ADDR_BITS-1:0] a, input pi1_word_t d,
		input logic [SEL_BITS-1:0] s);
		if (a >= 30'd1024 && a < 30'd2048) begin
			for (int b = 0; b < 4; b++) begin
				if (s[b])
					ref_mem[10'(a - 30'd1024)][b*8 +: 8] = d[b*8 +: 8];
			end
		end
	endfunction

	task automatic report_mismatch(input string what);
		err_count_o++;
		$display("mismatch at %0d ns: %s", $time, what);
	endtask

	initial begin
		err_count_o = 0;
		check_count_o = 0;
		timed_out_o = 1'b0;
		cycle_cnt = 0;
		exp_cnt = 0;
		exp_pwroff = 1'b0;
		exp_pending = 1'b0;
		prev_rst_p = 1'b0;
		model_valid = 1'b0;
		req_d1 = RST_REQ_NONE;
		req_d2 = RST_REQ_NONE;
	end

	// Inputs and outputs are all stable at the falling edge
	always @(negedge clk24mhz) begin
		// Reset state after the rising edge that just passed
		if (prev_rst_p) begin
			exp_cnt = 16;
			exp_pwroff = 1'b0;
			model_valid = 1'b1;
		end else begin
			if (req_d2 == RST_REQ_WARM)
				exp_cnt = 16;
			else if (exp_cnt != 0)
				exp_cnt--;
			if (req_d2 == RST_REQ_PWROFF)
				exp_pwroff = 1'b1;
		end
		exp_sys_rst = (exp_cnt != 0) || exp_pwroff;
		if (model_valid) begin
			check_count_o++;
			if (dut_sys_rst_i !== exp_sys_rst || dut_rdy_i !== !exp_sys_rst)
				report_mismatch($sformatf("sys_rst_o %b rdy_o %b, expected %b %b",
					dut_sys_rst_i, dut_rdy_i, exp_sys_rst, !exp_sys_rst));
		end
		if (exp_pending) begin
			check_count_o++;
			if (dut_data_i !== exp_data)
				report_mismatch($sformatf("data_o %h, expected %h", dut_data_i, exp_data));
		end

		// Request that the next rising edge accepts
		req_now = RST_REQ_NONE;
		exp_pending = 1'b0;
		if (dut_rdy_i === 1'b1 && op_i != PI1_NOP) begin
			if (op_i == PI1_RD || op_i == PI1_RDWR) begin
				exp_data = ref_read(addr_i);
				exp_pending = 1'b1;
			end
			if (op_i == PI1_WR || op_i == PI1_RDWR) begin
				ref_write(addr_i, data_i, sel_i);
				if (addr_i == '0 && sel_i[0] && data_i[1:0] == 2'b10)
					req_now = RST_REQ_WARM;
				else if (addr_i == '0 && sel_i[0] && data_i[1:0] == 2'b01)
					req_now = RST_REQ_PWROFF;
			end
		end
		// Request pulse reaches the counter two edges after acceptance
		req_d2 = req_d1;
		req_d1 = req_now;
		prev_rst_p = rst_p;
	end

	always @(posedge clk24mhz) begin
		cycle_cnt++;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			timed_out_o = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/perint_soc.sv ====
`default_nettype none

module perint_soc import pi1_pkg::*, soc_map_pkg::*; (
	input  logic                 clk24mhz,
	input  logic                 rst_p,
	input  pi1_op_e              op_i,
	input  logic [ADDR_BITS-1:0] addr_i,
	input  pi1_word_t            data_i,
	input  logic [SEL_BITS-1:0]  sel_i,
	output pi1_word_t            data_o,
	output logic                 rdy_o,
	output logic                 sys_rst_o
);

	rst_req_e rst_req;

	pi1_if devtbl_bus ();
	pi1_if ram_bus ();

	perint_router perint_router_i (
		.clk24mhz   (clk24mhz),
		.sys_rst_i  (sys_rst_o),
		.op_i       (op_i),
		.addr_i     (addr_i),
		.data_i     (data_i),
		.sel_i      (sel_i),
		.data_o     (data_o),
		.rdy_o      (rdy_o),
		.devtbl_bus (devtbl_bus.master),
		.ram_bus    (ram_bus.master)
	);

	// Table also carries the software reset requests
	devtbl devtbl_i (
		.clk24mhz  (clk24mhz),
		.sys_rst_i (sys_rst_o),
		.bus       (devtbl_bus.slave),
		.rst_req_o (rst_req)
	);

	scratch_ram scratch_ram_i (
		.clk24mhz (clk24mhz),
		.bus      (ram_bus.slave)
	);

	rst_ctrl rst_ctrl_i (
		.clk24mhz  (clk24mhz),
		.rst_p     (rst_p),
		.rst_req_i (rst_req),
		.sys_rst_o (sys_rst_o)
	);

endmodule

`default_nettype wire

// ==== hdl/rst_ctrl.sv ====
`default_nettype none

module rst_ctrl import soc_map_pkg::*; (
	input  logic     clk24mhz,
	input  logic     rst_p,
	input  rst_req_e rst_req_i,
	output logic     sys_rst_o
);

	logic [RST_CNT_BITS-1:0] hold_cnt;
	logic                    pwroff_q;

	// Hold counter, reloaded by external reset or a warm request
	always_ff @(posedge clk24mhz) begin
		if (rst_p)
			hold_cnt <= RST_CNT_BITS'(RST_HOLD_CYCLES);
		else if (rst_req_i == RST_REQ_WARM)
			hold_cnt <= RST_CNT_BITS'(RST_HOLD_CYCLES);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	// Power-off stays latched until the next external reset
	always_ff @(posedge clk24mhz) begin
		if (rst_p)
			pwroff_q <= 1'b0;
		else if (rst_req_i == RST_REQ_PWROFF)
			pwroff_q <= 1'b1;
	end

	assign sys_rst_o = (hold_cnt != '0) || pwroff_q;

	a_rst_follows: assert property (@(posedge clk24mhz) rst_p |=> sys_rst_o);

endmodule

`default_nettype wire

// ==== hdl/scratch_ram.sv ====
`default_nettype none

module scratch_ram import pi1_pkg::*, soc_map_pkg::*; (
	input  logic clk24mhz,
	pi1_if.slave bus
);

	pi1_word_t                      mem [RAM_WORDS];
	pi1_word_t                      rdata_q;
	logic [$clog2(RAM_WORDS)-1:0]   word_idx;
	logic                           is_rd;
	logic                           is_wr;

	assign word_idx = bus.addr[$clog2(RAM_WORDS)-1:0];
	assign is_rd = (bus.op == PI1_RD) || (bus.op == PI1_RDWR);
	assign is_wr = (bus.op == PI1_WR) || (bus.op == PI1_RDWR);

	// Read takes the word before this edge's write, which gives the swap
	always_ff @(posedge clk24mhz) begin
		if (is_rd)
			rdata_q <= mem[word_idx];
		if (is_wr) begin
			for (int b = 0; b < SEL_BITS; b++) begin
				if (bus.sel[b])
					mem[word_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
			end
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy = 1'b1;

	// Router offset must land inside the array
	a_in_range: assert property (@(posedge clk24mhz)
		bus.op != PI1_NOP |-> bus.addr < ADDR_BITS'(RAM_WORDS));

endmodule

`default_nettype wire

// ==== hdl/devtbl.sv ====
`default_nettype none

module devtbl import pi1_pkg::*, soc_map_pkg::*; (
	input  logic     clk24mhz,
	input  logic     sys_rst_i,
	pi1_if.slave     bus,
	output rst_req_e rst_req_o
);

	logic      is_rd;
	logic      is_wr;
	pi1_word_t tbl_word;
	pi1_word_t rdata_q;
	rst_req_e  req_d;
	rst_req_e  req_q;

	assign is_rd = (bus.op == PI1_RD) || (bus.op == PI1_RDWR);
	assign is_wr = (bus.op == PI1_WR) || (bus.op == PI1_RDWR);

	// Default device is entry 2 of the table
	always_comb begin
		tbl_word = '0;
		if (bus.addr < ADDR_BITS'(8)) begin
			case (bus.addr[2:0])
				3'd0: tbl_word = pi1_word_t'(SOC_ID);
				3'd1: tbl_word = pi1_word_t'(DEV_COUNT + 1);
				3'd2: tbl_word = pi1_word_t'(DEV_ID_DEVTBL);
				3'd3: tbl_word = pi1_word_t'(DEVTBL_MAPSZ);
				3'd4: tbl_word = pi1_word_t'(DEV_ID_RAM);
				3'd5: tbl_word = pi1_word_t'(RAM_MAPSZ);
				3'd6: tbl_word = pi1_word_t'(DEV_ID_INVALID);
				default: tbl_word = pi1_word_t'(INVALID_MAPSZ);
			endcase
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (is_rd)
			rdata_q <= tbl_word;
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy = 1'b1;

	// Reset request from the low byte of word 0
	always_comb begin
		req_d = RST_REQ_NONE;
		if (is_wr && bus.addr == '0 && bus.sel[0]) begin
			case (bus.wdata[1:0])
				2'b10:   req_d = RST_REQ_WARM;
				2'b01:   req_d = RST_REQ_PWROFF;
				default: req_d = RST_REQ_NONE;
			endcase
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i)
			req_q <= RST_REQ_NONE;
		else
			req_q <= req_d;
	end

	assign rst_req_o = req_q;

	a_req_pulse: assert property (@(posedge clk24mhz)
		rst_req_o != RST_REQ_NONE |=> rst_req_o == RST_REQ_NONE);

endmodule

`default_nettype wire

// ==== hdl/perint_router.sv ====
`default_nettype none

module perint_router import pi1_pkg::*, soc_map_pkg::*; (
	input  logic                 clk24mhz,
	input  logic                 sys_rst_i,
	input  pi1_op_e              op_i,
	input  logic [ADDR_BITS-1:0] addr_i,
	input  pi1_word_t            data_i,
	input  logic [SEL_BITS-1:0]  sel_i,
	output pi1_word_t            data_o,
	output logic                 rdy_o,
	pi1_if.master                devtbl_bus,
	pi1_if.master                ram_bus
);

	logic       hit_devtbl;
	logic       hit_ram;
	logic       rd_accept;
	logic [1:0] dev_sel;
	logic [1:0] dev_sel_q;

	// Regions are consecutive from word 0 and anything past them is the default device
	assign hit_devtbl = (addr_i < ADDR_BITS'(DEVTBL_WORDS));
	assign hit_ram = (addr_i >= ADDR_BITS'(DEVTBL_WORDS)) &&
		(addr_i < ADDR_BITS'(DEVTBL_WORDS + RAM_WORDS));

	always_comb begin
		if (hit_devtbl)
			dev_sel = 2'(DEV_DEVTBL);
		else if (hit_ram)
			dev_sel = 2'(DEV_RAM);
		else
			dev_sel = 2'(DEV_COUNT);
	end

	// No back-pressure, so ready only drops during system reset
	assign rdy_o = !sys_rst_i && devtbl_bus.rdy && ram_bus.rdy;

	// Only the addressed device sees the operation and the other gets a NOP
	assign devtbl_bus.op = (rdy_o && hit_devtbl) ? op_i : PI1_NOP;
	assign ram_bus.op = (rdy_o && hit_ram) ? op_i : PI1_NOP;

	assign devtbl_bus.addr = addr_i;
	assign ram_bus.addr = addr_i - ADDR_BITS'(DEVTBL_WORDS);

	assign devtbl_bus.wdata = data_i;
	assign devtbl_bus.sel = sel_i;
	assign ram_bus.wdata = data_i;
	assign ram_bus.sel = sel_i;

	assign rd_accept = rdy_o && (op_i == PI1_RD || op_i == PI1_RDWR);

	// Remember who answers the read so the response can be picked next cycle
	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i)
			dev_sel_q <= 2'(DEV_COUNT);
		else if (rd_accept)
			dev_sel_q <= dev_sel;
	end

	always_comb begin
		case (dev_sel_q)
			2'(DEV_DEVTBL): data_o = devtbl_bus.rdata;
			2'(DEV_RAM):    data_o = ram_bus.rdata;
			// Default device reads as zero
			default:        data_o = '0;
		endcase
	end

	a_one_target: assert property (@(posedge clk24mhz)
		!(devtbl_bus.op != PI1_NOP && ram_bus.op != PI1_NOP));

endmodule

`default_nettype wire

// ==== hdl/pi1_if.sv ====
`default_nettype none

interface pi1_if import pi1_pkg::*; ();

	// Request side, driven by the router
	pi1_op_e              op;
	logic [ADDR_BITS-1:0] addr;
	pi1_word_t            wdata;
	logic [SEL_BITS-1:0]  sel;

	// Response side, driven by the device
	pi1_word_t            rdata;
	logic                 rdy;

	modport master(output op, output addr, output wdata, output sel,
		input rdata, input rdy);

	modport slave(input op, input addr, input wdata, input sel,
		output rdata, output rdy);

endinterface

`default_nettype wire

// ==== hdl/soc_map_pkg.sv ====
`default_nettype none

package soc_map_pkg;

	// Device indices, also the order of the regions from address 0
	localparam int unsigned DEV_DEVTBL = 0;
	localparam int unsigned DEV_RAM = 1;
	localparam int unsigned DEV_COUNT = 2;

	// Region sizes in bytes
	localparam int unsigned DEVTBL_MAPSZ = 4096;
	localparam int unsigned RAM_MAPSZ = 4096;
	localparam int unsigned INVALID_MAPSZ = 4096;

	// Region sizes in 32-bit words
	localparam int unsigned DEVTBL_WORDS = DEVTBL_MAPSZ / 4;
	localparam int unsigned RAM_WORDS = RAM_MAPSZ / 4;

	// Identifiers reported by the device table
	localparam int unsigned DEV_ID_DEVTBL = 7;
	localparam int unsigned DEV_ID_RAM = 1;
	localparam int unsigned DEV_ID_INVALID = 0;
	localparam int unsigned SOC_ID = 5;

	// System reset hold time
	localparam int unsigned RST_HOLD_CYCLES = 16;
	localparam int unsigned RST_CNT_BITS = 5;

	// Encoded the same way as data bits 1 and 0 of the request write
	typedef enum logic [1:0] {
		RST_REQ_NONE   = 2'b00,
		RST_REQ_PWROFF = 2'b01,
		RST_REQ_WARM   = 2'b10
	} rst_req_e;

endpackage

`default_nettype wire

// ==== hdl/pi1_pkg.sv ====
`default_nettype none

package pi1_pkg;

	// Data width of the peripheral interconnect
	localparam int unsigned ARCH_BITS = 32;

	// One select bit per byte lane
	localparam int unsigned SEL_BITS = ARCH_BITS / 8;

	// Word address, byte offset bits dropped
	localparam int unsigned ADDR_BITS = ARCH_BITS - $clog2(SEL_BITS);

	// Operation codes carried on the op lines
	// RDWR is a swap that returns the old word and writes the new one
	typedef enum logic [1:0] {
		PI1_NOP  = 2'b00,
		PI1_WR   = 2'b01,
		PI1_RD   = 2'b10,
		PI1_RDWR = 2'b11
	} pi1_op_e;

	typedef logic [ARCH_BITS-1:0] pi1_word_t;

endpackage

`default_nettype wire
